/* hdl/axi4s_pkg.sv */
// stream definitions for the byte-lane packet stream
// data width, byte lane count and the tid and tdest side-band types

package axi4s_pkg;

   // ----------------------------------------
   // data path widths
   // ----------------------------------------

   // number of byte lanes carried in one beat
   localparam int DATA_BYTE_WID = 8;

   // data width in bits, one byte per lane
   localparam int DATA_WID = DATA_BYTE_WID * 8;

   // width of a count of kept bytes, which runs from 0 up to DATA_BYTE_WID
   localparam int KEEP_CNT_WID = $clog2(DATA_BYTE_WID + 1);

   // ----------------------------------------
   // side-band fields
   // ----------------------------------------

   // widths of the stream id and destination fields
   localparam int TID_WID   = 4;
   localparam int TDEST_WID = 4;

   // stream id, carried unchanged on every beat of a packet
   typedef logic [TID_WID-1:0] tid_t;

   // stream destination, also constant over a packet
   typedef logic [TDEST_WID-1:0] tdest_t;

endpackage : axi4s_pkg

/* hdl/buffer_ctx_pkg.sv */
// buffer context definitions
// write pointer type and the width of the header length input

package buffer_ctx_pkg;

   // width of the buffer write pointer
   localparam int PTR_LEN = 16;

   // buffer write pointer, one step per accepted ingress beat
   // it wraps silently at its width
   typedef logic [PTR_LEN-1:0] wr_ptr_t;

   // width of the header length input, counted in bytes
   // a length of zero is not a legal setting
   localparam int HDR_LEN_WID = 16;

endpackage : buffer_ctx_pkg

/* hdl/axi4s_copy.sv */
// two-way stream fork
// each accepted ingress beat is registered into two branch slots, and
// each branch drains its slot under its own ready

`timescale 1ns/100ps

module axi4s_copy (
   input  logic                                axi4s_in,
   input  logic                                arst_n,

   // ingress beat plus its buffer write pointer
   input  logic                                in_tvalid,
   output logic                                in_tready,
   input  logic [axi4s_pkg::DATA_WID-1:0]      in_tdata,
   input  logic [axi4s_pkg::DATA_BYTE_WID-1:0] in_tkeep,
   input  logic                                in_tlast,
   input  axi4s_pkg::tid_t                     in_tid,
   input  axi4s_pkg::tdest_t                   in_tdest,
   input  buffer_ctx_pkg::wr_ptr_t             in_wr_ptr,

   // branch a, the bit-exact packet copy
   output logic                                a_tvalid,
   input  logic                                a_tready,
   output logic [axi4s_pkg::DATA_WID-1:0]      a_tdata,
   output logic [axi4s_pkg::DATA_BYTE_WID-1:0] a_tkeep,
   output logic                                a_tlast,
   output axi4s_pkg::tid_t                     a_tid,
   output axi4s_pkg::tdest_t                   a_tdest,

   // branch b, the copy that carries the write pointer on
   output logic                                b_tvalid,
   input  logic                                b_tready,
   output logic [axi4s_pkg::DATA_WID-1:0]      b_tdata,
   output logic [axi4s_pkg::DATA_BYTE_WID-1:0] b_tkeep,
   output logic                                b_tlast,
   output axi4s_pkg::tid_t                     b_tid,
   output axi4s_pkg::tdest_t                   b_tdest,
   output buffer_ctx_pkg::wr_ptr_t             b_wr_ptr
);

   // goes high on the first edge after reset and then stays high
   logic run;
   logic in_xfer;

   // ----------------------------------------
   // ingress handshake
   // ----------------------------------------

   // a slot can take a new beat when it is empty or drains in this cycle
   // both slots must be able to, since every beat goes to both branches
   assign in_tready = run && (!a_tvalid || a_tready) && (!b_tvalid || b_tready);
   assign in_xfer   = in_tvalid && in_tready;

   // ----------------------------------------
   // slot valid flags
   // ----------------------------------------

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         run      <= 1'b0;
         a_tvalid <= 1'b0;
         b_tvalid <= 1'b0;
      end else begin
         run <= 1'b1;
         // a load wins over a drain in the same cycle, since the slot refills
         if (in_xfer) begin
            a_tvalid <= 1'b1;
         end else if (a_tready) begin
            a_tvalid <= 1'b0;
         end
         if (in_xfer) begin
            b_tvalid <= 1'b1;
         end else if (b_tready) begin
            b_tvalid <= 1'b0;
         end
      end
   end

   // payload of both slots, loaded together on every ingress transfer
   always_ff @(posedge axi4s_in) begin
      if (in_xfer) begin
         a_tdata  <= in_tdata;
         a_tkeep  <= in_tkeep;
         a_tlast  <= in_tlast;
         a_tid    <= in_tid;
         a_tdest  <= in_tdest;
         b_tdata  <= in_tdata;
         b_tkeep  <= in_tkeep;
         b_tlast  <= in_tlast;
         b_tid    <= in_tid;
         b_tdest  <= in_tdest;
         b_wr_ptr <= in_wr_ptr;
      end
   end

endmodule : axi4s_copy

/* hdl/axi4s_trunc.sv */
// header truncator
// forwards the first length bytes of each packet, ends the header with
// tlast on a trimmed beat, and swallows the remainder of the packet

`timescale 1ns/100ps

module axi4s_trunc #(
   // selects the lanes kept in a trimmed beat, low lanes when 0
   parameter logic BIGENDIAN = 1'b0
) (
   input  logic                                  axi4s_in,
   input  logic                                  arst_n,

   // header length in bytes, never zero
   input  logic [buffer_ctx_pkg::HDR_LEN_WID-1:0] length,

   input  logic                                  in_tvalid,
   output logic                                  in_tready,
   input  logic [axi4s_pkg::DATA_WID-1:0]        in_tdata,
   input  logic [axi4s_pkg::DATA_BYTE_WID-1:0]   in_tkeep,
   input  logic                                  in_tlast,
   input  axi4s_pkg::tid_t                       in_tid,
   input  axi4s_pkg::tdest_t                     in_tdest,
   input  buffer_ctx_pkg::wr_ptr_t               in_wr_ptr,

   output logic                                  out_tvalid,
   input  logic                                  out_tready,
   output logic [axi4s_pkg::DATA_WID-1:0]        out_tdata,
   output logic [axi4s_pkg::DATA_BYTE_WID-1:0]   out_tkeep,
   output logic                                  out_tlast,
   output axi4s_pkg::tid_t                       out_tid,
   output axi4s_pkg::tdest_t                     out_tdest,
   output buffer_ctx_pkg::wr_ptr_t               out_wr_ptr
);

   // bytes already forwarded in the current packet
   logic [buffer_ctx_pkg::HDR_LEN_WID-1:0]   byte_cnt;
   // set once the header is complete, until the packet ends
   logic                                     discard;

   logic [axi4s_pkg::KEEP_CNT_WID-1:0]       beat_bytes;
   logic [buffer_ctx_pkg::HDR_LEN_WID:0]     byte_sum;
   logic [buffer_ctx_pkg::HDR_LEN_WID-1:0]   remain;
   logic [axi4s_pkg::KEEP_CNT_WID-1:0]       remain_bytes;
   logic [axi4s_pkg::DATA_BYTE_WID-1:0]      cut_mask;
   logic                                     reach;
   logic                                     in_xfer;

   // number of kept bytes in a beat
   function automatic logic [axi4s_pkg::KEEP_CNT_WID-1:0] keep_count(
      input logic [axi4s_pkg::DATA_BYTE_WID-1:0] keep
   );
      logic [axi4s_pkg::KEEP_CNT_WID-1:0] n;
      n = '0;
      for (int i = 0; i < axi4s_pkg::DATA_BYTE_WID; i++) begin
         if (keep[i]) begin
            n = n + 1'b1;
         end
      end
      return n;
   endfunction

   // ----------------------------------------
   // header boundary
   // ----------------------------------------

   assign beat_bytes = keep_count(in_tkeep);

   // one extra bit so the sum cannot wrap near the top of the length range
   assign byte_sum = {1'b0, byte_cnt} +
                     {{(buffer_ctx_pkg::HDR_LEN_WID + 1 - axi4s_pkg::KEEP_CNT_WID){1'b0}},
                      beat_bytes};

   // this beat fills the header, exactly or with bytes to spare
   assign reach = (byte_sum >= {1'b0, length});

   // bytes still owed to the header; only the low bits matter once reach is
   // set, because then the count is at most one full beat
   assign remain       = length - byte_cnt;
   assign remain_bytes = remain[axi4s_pkg::KEEP_CNT_WID-1:0];

   // low lanes count from byte 0, high lanes from the top lane down
   assign cut_mask = BIGENDIAN ? ~({axi4s_pkg::DATA_BYTE_WID{1'b1}} >> remain_bytes)
                               : ~({axi4s_pkg::DATA_BYTE_WID{1'b1}} << remain_bytes);

   // ----------------------------------------
   // data path
   // ----------------------------------------

   // beats after the header are taken at once and never shown downstream
   assign in_tready  = discard || out_tready;
   assign in_xfer    = in_tvalid && in_tready;

   assign out_tvalid = in_tvalid && !discard;
   assign out_tdata  = in_tdata;
   assign out_tkeep  = reach ? (in_tkeep & cut_mask) : in_tkeep;
   assign out_tlast  = in_tlast || reach;
   assign out_tid    = in_tid;
   assign out_tdest  = in_tdest;
   assign out_wr_ptr = in_wr_ptr;

   // byte count and discard flag, both back to packet start on every tlast
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         byte_cnt <= '0;
         discard  <= 1'b0;
      end else if (in_xfer) begin
         if (in_tlast) begin
            byte_cnt <= '0;
            discard  <= 1'b0;
         end else if (!discard) begin
            if (reach) begin
               discard <= 1'b1;
            end else begin
               byte_cnt <= byte_sum[buffer_ctx_pkg::HDR_LEN_WID-1:0];
            end
         end
      end
   end

endmodule : axi4s_trunc

/* hdl/axi4s_split.sv */
// packet header splitter
// returns each ingress packet untouched and, beside it, a header stream
// of the first hdr_length bytes tagged with the buffer write pointer

`timescale 1ns/100ps

module axi4s_split #(
   // lane order of a trimmed header beat, passed to the truncator
   parameter logic BIGENDIAN = 1'b0
) (
   input  logic                                   axi4s_in,
   input  logic                                   arst_n,

   // ingress packet stream
   input  logic                                   in_tvalid,
   output logic                                   in_tready,
   input  logic [axi4s_pkg::DATA_WID-1:0]         in_tdata,
   input  logic [axi4s_pkg::DATA_BYTE_WID-1:0]    in_tkeep,
   input  logic                                   in_tlast,
   input  axi4s_pkg::tid_t                        in_tid,
   input  axi4s_pkg::tdest_t                      in_tdest,

   // packet egress, a copy of the ingress
   output logic                                   out_tvalid,
   input  logic                                   out_tready,
   output logic [axi4s_pkg::DATA_WID-1:0]         out_tdata,
   output logic [axi4s_pkg::DATA_BYTE_WID-1:0]    out_tkeep,
   output logic                                   out_tlast,
   output axi4s_pkg::tid_t                        out_tid,
   output axi4s_pkg::tdest_t                      out_tdest,

   // header egress
   output logic                                   hdr_tvalid,
   input  logic                                   hdr_tready,
   output logic [axi4s_pkg::DATA_WID-1:0]         hdr_tdata,
   output logic [axi4s_pkg::DATA_BYTE_WID-1:0]    hdr_tkeep,
   output logic                                   hdr_tlast,
   output axi4s_pkg::tid_t                        hdr_tid,
   output axi4s_pkg::tdest_t                      hdr_tdest,
   output buffer_ctx_pkg::wr_ptr_t                hdr_wr_ptr,

   // header length in bytes
   input  logic [buffer_ctx_pkg::HDR_LEN_WID-1:0] hdr_length
);

   // buffer address of the next ingress beat
   buffer_ctx_pkg::wr_ptr_t                wr_ptr;

   // branch b of the fork, on its way into the truncator
   logic                                   b_tvalid;
   logic                                   b_tready;
   logic [axi4s_pkg::DATA_WID-1:0]         b_tdata;
   logic [axi4s_pkg::DATA_BYTE_WID-1:0]    b_tkeep;
   logic                                   b_tlast;
   axi4s_pkg::tid_t                        b_tid;
   axi4s_pkg::tdest_t                      b_tdest;
   buffer_ctx_pkg::wr_ptr_t                b_wr_ptr;

   // ----------------------------------------
   // write pointer
   // ----------------------------------------

   // one step per accepted ingress beat, wrapping at the pointer width
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
      end else if (in_tvalid && in_tready) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // ----------------------------------------
   // fork and truncator
   // ----------------------------------------

   // branch a goes straight to the packet egress
   axi4s_copy copy_0 (
      .axi4s_in  (axi4s_in),
      .arst_n    (arst_n),
      .in_tvalid (in_tvalid),
      .in_tready (in_tready),
      .in_tdata  (in_tdata),
      .in_tkeep  (in_tkeep),
      .in_tlast  (in_tlast),
      .in_tid    (in_tid),
      .in_tdest  (in_tdest),
      .in_wr_ptr (wr_ptr),
      .a_tvalid  (out_tvalid),
      .a_tready  (out_tready),
      .a_tdata   (out_tdata),
      .a_tkeep   (out_tkeep),
      .a_tlast   (out_tlast),
      .a_tid     (out_tid),
      .a_tdest   (out_tdest),
      .b_tvalid  (b_tvalid),
      .b_tready  (b_tready),
      .b_tdata   (b_tdata),
      .b_tkeep   (b_tkeep),
      .b_tlast   (b_tlast),
      .b_tid     (b_tid),
      .b_tdest   (b_tdest),
      .b_wr_ptr  (b_wr_ptr)
   );

   // past the header the truncator keeps b_tready high, so hdr_tready
   // holds up ingress only inside the header region
   axi4s_trunc #(
      .BIGENDIAN (BIGENDIAN)
   ) trunc_0 (
      .axi4s_in   (axi4s_in),
      .arst_n     (arst_n),
      .length     (hdr_length),
      .in_tvalid  (b_tvalid),
      .in_tready  (b_tready),
      .in_tdata   (b_tdata),
      .in_tkeep   (b_tkeep),
      .in_tlast   (b_tlast),
      .in_tid     (b_tid),
      .in_tdest   (b_tdest),
      .in_wr_ptr  (b_wr_ptr),
      .out_tvalid (hdr_tvalid),
      .out_tready (hdr_tready),
      .out_tdata  (hdr_tdata),
      .out_tkeep  (hdr_tkeep),
      .out_tlast  (hdr_tlast),
      .out_tid    (hdr_tid),
      .out_tdest  (hdr_tdest),
      .out_wr_ptr (hdr_wr_ptr)
   );

endmodule : axi4s_split

/* tests/tb_clock.sv */
// testbench clock and reset generator
// 100 ns clock, reset held low for the first 8 rising edges

`timescale 1ns/100ps

module tb_clock (
   output logic axi4s_in,
   output logic arst_n
);

   // half of the 100 ns period
   localparam time HALF_PERIOD = 50ns;

   initial begin
      axi4s_in = 1'b0;
      forever begin
         #(HALF_PERIOD) axi4s_in = ~axi4s_in;
      end
   end

   // reset is released on a rising edge, like every other stimulus
   initial begin
      arst_n = 1'b0;
      repeat (8) @(posedge axi4s_in);
      arst_n <= 1'b1;
   end

endmodule : tb_clock

/* tests/tb_axi4s_split.sv */
// directed testbench for the packet header splitter
// pushes random packets through the DUT and checks the packet egress and
// the header egress against queues filled by a byte-level model

`timescale 1ns/100ps

module tb_axi4s_split;

   // all tests together take roughly 2000 cycles with back-pressure on
   localparam int TIMEOUT_CYCLES = 4000;

   // one beat as the model sees it, ptr is only checked on the header side
   typedef struct packed {
      logic [axi4s_pkg::DATA_WID-1:0]      data;
      logic [axi4s_pkg::DATA_BYTE_WID-1:0] keep;
      logic                                last;
      axi4s_pkg::tid_t                     tid;
      axi4s_pkg::tdest_t                   tdest;
      buffer_ctx_pkg::wr_ptr_t             ptr;
   } beat_t;

   logic                                   axi4s_in;
   logic                                   arst_n;
   logic                                   in_tvalid;
   logic                                   in_tready;
   logic [axi4s_pkg::DATA_WID-1:0]         in_tdata;
   logic [axi4s_pkg::DATA_BYTE_WID-1:0]    in_tkeep;
   logic                                   in_tlast;
   axi4s_pkg::tid_t                        in_tid;
   axi4s_pkg::tdest_t                      in_tdest;
   logic                                   out_tvalid;
   logic                                   out_tready;
   logic [axi4s_pkg::DATA_WID-1:0]         out_tdata;
   logic [axi4s_pkg::DATA_BYTE_WID-1:0]    out_tkeep;
   logic                                   out_tlast;
   axi4s_pkg::tid_t                        out_tid;
   axi4s_pkg::tdest_t                      out_tdest;
   logic                                   hdr_tvalid;
   logic                                   hdr_tready;
   logic [axi4s_pkg::DATA_WID-1:0]         hdr_tdata;
   logic [axi4s_pkg::DATA_BYTE_WID-1:0]    hdr_tkeep;
   logic                                   hdr_tlast;
   axi4s_pkg::tid_t                        hdr_tid;
   axi4s_pkg::tdest_t                      hdr_tdest;
   buffer_ctx_pkg::wr_ptr_t                hdr_wr_ptr;
   logic [buffer_ctx_pkg::HDR_LEN_WID-1:0] hdr_length;

   // expected beats, in the order the DUT must deliver them
   beat_t out_q[$];
   beat_t hdr_q[$];
   beat_t out_exp;
   beat_t hdr_exp;
   // ingress beats handed to the model so far, the next write pointer
   int    beats_sent;
   // random ready on both egress ports while set
   logic  bp_on;
   int    cycles;
   int    reset_errs;
   int    out_errs;
   int    hdr_errs;

   tb_clock clk_gen (
      .axi4s_in (axi4s_in),
      .arst_n   (arst_n)
   );

   axi4s_split #(
      .BIGENDIAN (1'b0)
   ) dut (
      .axi4s_in   (axi4s_in),
      .arst_n     (arst_n),
      .in_tvalid  (in_tvalid),
      .in_tready  (in_tready),
      .in_tdata   (in_tdata),
      .in_tkeep   (in_tkeep),
      .in_tlast   (in_tlast),
      .in_tid     (in_tid),
      .in_tdest   (in_tdest),
      .out_tvalid (out_tvalid),
      .out_tready (out_tready),
      .out_tdata  (out_tdata),
      .out_tkeep  (out_tkeep),
      .out_tlast  (out_tlast),
      .out_tid    (out_tid),
      .out_tdest  (out_tdest),
      .hdr_tvalid (hdr_tvalid),
      .hdr_tready (hdr_tready),
      .hdr_tdata  (hdr_tdata),
      .hdr_tkeep  (hdr_tkeep),
      .hdr_tlast  (hdr_tlast),
      .hdr_tid    (hdr_tid),
      .hdr_tdest  (hdr_tdest),
      .hdr_wr_ptr (hdr_wr_ptr),
      .hdr_length (hdr_length)
   );

   // widen a byte keep into a bit mask over the data word
   function automatic logic [axi4s_pkg::DATA_WID-1:0] lane_mask(
      input logic [axi4s_pkg::DATA_BYTE_WID-1:0] keep
   );
      logic [axi4s_pkg::DATA_WID-1:0] m;
      for (int i = 0; i < axi4s_pkg::DATA_BYTE_WID; i++) begin
         m[i*8 +: 8] = {8{keep[i]}};
      end
      return m;
   endfunction

   // ----------------------------------------
   // ingress driver and model
   // ----------------------------------------

   // called on a rising edge, returns on the edge that takes the beat
   task automatic drive_beat(input beat_t beat);
      in_tvalid <= 1'b1;
      in_tdata  <= beat.data;
      in_tkeep  <= beat.keep;
      in_tlast  <= beat.last;
      in_tid    <= beat.tid;
      in_tdest  <= beat.tdest;
      // in_tready only moves on rising edges, so the falling edge is safe
      @(negedge axi4s_in);
      while (!in_tready) begin
         @(negedge axi4s_in);
      end
      @(posedge axi4s_in);
   endtask

   // builds one packet, queues what both egress ports must show, drives it
   task automatic send_packet(input int nbeats, input int len);
      beat_t             pkt[$];
      beat_t             beat;
      beat_t             hbeat;
      int                tail;
      int                total;
      int                hdr_bytes;
      axi4s_pkg::tid_t   tid;
      axi4s_pkg::tdest_t tdest;
      tid       = axi4s_pkg::tid_t'($urandom);
      tdest     = axi4s_pkg::tdest_t'($urandom);
      tail      = 1 + int'($urandom % axi4s_pkg::DATA_BYTE_WID);
      total     = (nbeats - 1) * axi4s_pkg::DATA_BYTE_WID + tail;
      // the header is the first len bytes, or the whole packet if shorter
      hdr_bytes = (len < total) ? len : total;
      for (int i = 0; i < nbeats; i++) begin
         beat.data  = {$urandom, $urandom};
         beat.keep  = {axi4s_pkg::DATA_BYTE_WID{1'b1}};
         if (i == nbeats - 1) begin
            beat.keep = beat.keep >> (axi4s_pkg::DATA_BYTE_WID - tail);
         end
         beat.last  = (i == nbeats - 1);
         beat.tid   = tid;
         beat.tdest = tdest;
         beat.ptr   = buffer_ctx_pkg::wr_ptr_t'(beats_sent);
         beats_sent++;
         out_q.push_back(beat);
         // a lane belongs to the header when its byte offset is below hdr_bytes
         hbeat = beat;
         for (int j = 0; j < axi4s_pkg::DATA_BYTE_WID; j++) begin
            hbeat.keep[j] = beat.keep[j] && (i * axi4s_pkg::DATA_BYTE_WID + j < hdr_bytes);
         end
         if (hbeat.keep != '0) begin
            hbeat.last = ((i + 1) * axi4s_pkg::DATA_BYTE_WID >= hdr_bytes);
            hdr_q.push_back(hbeat);
         end
         pkt.push_back(beat);
      end
      foreach (pkt[i]) begin
         drive_beat(pkt[i]);
      end
   endtask

   // the length may only change while the truncator sits at packet start
   task automatic set_length(input int len);
      @(posedge axi4s_in);
      hdr_length <= buffer_ctx_pkg::HDR_LEN_WID'(len);
   endtask

   // idle the ingress and wait until every expected beat has been seen
   task automatic drain_traffic();
      in_tvalid <= 1'b0;
      while (out_q.size() != 0 || hdr_q.size() != 0) begin
         @(posedge axi4s_in);
      end
      // lets discarded beats leave branch b before the length moves
      repeat (4) @(posedge axi4s_in);
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------

   task automatic reset_state();
      @(negedge axi4s_in);
      assert (!in_tready && !out_tvalid && !hdr_tvalid) else begin
         $display("Mismatch at %0t: handshake outputs not low during reset", $time);
         reset_errs++;
      end
      wait (arst_n);
      @(negedge axi4s_in);
      assert (!out_tvalid && !hdr_tvalid) else begin
         $display("Mismatch at %0t: egress valid high before any traffic", $time);
         reset_errs++;
      end
   endtask

   // every packet length from 1 to 9 beats, ready held high
   task automatic pass_through();
      set_length(20);
      for (int n = 1; n <= 9; n++) begin
         send_packet(n, 20);
      end
      drain_traffic();
   endtask

   task automatic header_cut();
      int lens[4] = '{5, 8, 13, 20};
      foreach (lens[k]) begin
         set_length(lens[k]);
         repeat (6) send_packet(1 + int'($urandom % 9), lens[k]);
         drain_traffic();
      end
   endtask

   // at most 16 bytes per packet, below the 20 byte header
   task automatic short_packets();
      set_length(20);
      repeat (8) send_packet(1 + int'($urandom % 2), 20);
      drain_traffic();
   endtask

   task automatic back_pressure();
      bp_on <= 1'b1;
      set_length(13);
      repeat (25) send_packet(1 + int'($urandom % 9), 13);
      drain_traffic();
      bp_on <= 1'b0;
   endtask

   // ----------------------------------------
   // egress ready and monitors
   // ----------------------------------------

   always @(posedge axi4s_in) begin
      if (bp_on) begin
         out_tready <= ($urandom % 2) == 0;
         hdr_tready <= ($urandom % 3) != 0;
      end else begin
         out_tready <= 1'b1;
         hdr_tready <= 1'b1;
      end
   end

   // valid and ready high at the falling edge means a transfer on the next rise
   always @(negedge axi4s_in) begin
      if (arst_n && out_tvalid && out_tready) begin
         assert (out_q.size() != 0) else begin
            $display("packet egress sent a beat at %0t that the model did not expect", $time);
            out_errs++;
         end
         if (out_q.size() != 0) begin
            out_exp = out_q.pop_front();
            assert (out_tdata == out_exp.data && out_tkeep == out_exp.keep &&
                    out_tlast == out_exp.last && out_tid == out_exp.tid &&
                    out_tdest == out_exp.tdest) else begin
               $display("Mismatch at %0t: packet beat %h keep %h last %b, expected %h %h %b",
                        $time, out_tdata, out_tkeep, out_tlast,
                        out_exp.data, out_exp.keep, out_exp.last);
               out_errs++;
            end
         end
      end
   end

   // only kept lanes of header data are compared
   always @(negedge axi4s_in) begin
      if (arst_n && hdr_tvalid && hdr_tready) begin
         assert (hdr_q.size() != 0) else begin
            $display("header egress sent a beat at %0t that the model did not expect", $time);
            hdr_errs++;
         end
         if (hdr_q.size() != 0) begin
            hdr_exp = hdr_q.pop_front();
            assert ((hdr_tdata & lane_mask(hdr_exp.keep)) ==
                    (hdr_exp.data & lane_mask(hdr_exp.keep)) &&
                    hdr_tkeep == hdr_exp.keep && hdr_tlast == hdr_exp.last &&
                    hdr_tid == hdr_exp.tid && hdr_tdest == hdr_exp.tdest) else begin
               $display("Mismatch at %0t: header beat %h keep %h last %b, expected %h %h %b",
                        $time, hdr_tdata, hdr_tkeep, hdr_tlast,
                        hdr_exp.data, hdr_exp.keep, hdr_exp.last);
               hdr_errs++;
            end
            assert (hdr_wr_ptr == hdr_exp.ptr) else begin
               $display("Mismatch at %0t: header write pointer %0d, expected %0d",
                        $time, hdr_wr_ptr, hdr_exp.ptr);
               hdr_errs++;
            end
         end
      end
   end

   // ----------------------------------------
   // watchdog and main sequence
   // ----------------------------------------

   always @(posedge axi4s_in) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("run stopped after %0d cycles because traffic never drained", cycles);
         $display("errors: reset %0d, packet egress %0d, header egress %0d",
                  reset_errs, out_errs, hdr_errs);
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'hd169));
      in_tvalid  = 1'b0;
      in_tdata   = '0;
      in_tkeep   = '0;
      in_tlast   = 1'b0;
      in_tid     = '0;
      in_tdest   = '0;
      out_tready = 1'b1;
      hdr_tready = 1'b1;
      hdr_length = 16'd20;
      bp_on      = 1'b0;
      beats_sent = 0;
      cycles     = 0;
      reset_errs = 0;
      out_errs   = 0;
      hdr_errs   = 0;

      reset_state();
      pass_through();
      header_cut();
      short_packets();
      back_pressure();

      $display("errors: reset %0d, packet egress %0d, header egress %0d",
               reset_errs, out_errs, hdr_errs);
      if (reset_errs + out_errs + hdr_errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule : tb_axi4s_split

/* verilog.f */
hdl/axi4s_pkg.sv
hdl/buffer_ctx_pkg.sv
hdl/axi4s_copy.sv
hdl/axi4s_trunc.sv
hdl/axi4s_split.sv
tests/tb_clock.sv
tests/tb_axi4s_split.sv

/* Makefile */
# Verilator build for the packet header splitter
# every variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_axi4s_split
DUT_TOP   ?= axi4s_split
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Everything OK

SRCS := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides the result, so a missing pass line fails the target
sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
